//--- hw/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Data word width
`define ALU_WIDTH 8

// Opcode width for eight operations
`define ALU_OP_WIDTH 3

// Barrel shifter depth as log2 of the word width
`define ALU_SHIFT_STAGES 3

`endif

//--- hw/alu_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

    // Operation select in datapath encoding order
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        op_mov           = 3'b000,
        op_add           = 3'b001,
        op_and           = 3'b010,
        op_or            = 3'b011,
        op_mul           = 3'b100,
        op_shift_logical = 3'b101,
        op_shift_arith   = 3'b110,
        op_rotate        = 3'b111
    } alu_op_e;

    // Fill behavior of the shared barrel shifter
    typedef enum logic [1:0] {
        kind_logical = 2'd0,
        kind_arith   = 2'd1,
        kind_rotate  = 2'd2
    } shift_kind_e;

endpackage

`default_nettype wire

//--- hw/shift_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module shift_control (
    input  wire alu_pkg::alu_op_e             opcode,
    input  wire [`ALU_WIDTH-1:0]              amount,
    output logic                              shift_right,
    output alu_pkg::shift_kind_e              shift_kind,
    output logic [`ALU_SHIFT_STAGES-1:0]      offset,
    output logic                              out_of_range
);

    logic [`ALU_WIDTH-1:0] magnitude;

    always_comb begin
        case (opcode)
            alu_pkg::op_shift_arith: shift_kind = alu_pkg::kind_arith;
            alu_pkg::op_rotate:      shift_kind = alu_pkg::kind_rotate;
            default:                 shift_kind = alu_pkg::kind_logical;
        endcase
    end

    // Negative amount means shift right by its magnitude
    assign shift_right = amount[`ALU_WIDTH-1];
    assign magnitude   = amount[`ALU_WIDTH-1] ? -amount : amount;

    // Low bits steer the stages, upper bits only matter for range
    assign offset = magnitude[`ALU_SHIFT_STAGES-1:0];

    // Rotate wraps modulo the width, so it never saturates
    assign out_of_range = (magnitude[`ALU_WIDTH-1:`ALU_SHIFT_STAGES] != '0) &&
                          (shift_kind != alu_pkg::kind_rotate);

endmodule

`default_nettype wire

//--- hw/shift_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module shift_stage #(
    parameter int STAGE = 0
) (
    input  wire [`ALU_WIDTH-1:0]        data_in,
    input  wire                         enable,
    input  wire                         shift_right,
    input  wire alu_pkg::shift_kind_e   shift_kind,
    output logic [`ALU_WIDTH-1:0]       data_out
);

    localparam int W    = `ALU_WIDTH;
    localparam int DIST = 2 ** STAGE;

    logic          sign;
    logic [W-1:0]  moved;

    assign sign = data_in[W-1];

    always_comb begin
        case (shift_kind)
            alu_pkg::kind_rotate: begin
                if (shift_right) begin
                    moved = {data_in[DIST-1:0], data_in[W-1:DIST]};
                end else begin
                    moved = {data_in[W-DIST-1:0], data_in[W-1:W-DIST]};
                end
            end
            alu_pkg::kind_arith: begin
                if (shift_right) begin
                    moved = {{DIST{sign}}, data_in[W-1:DIST]};
                end else begin
                    // Sign bit stays put, the rest moves left
                    moved = {sign, data_in[W-2-DIST:0], {DIST{1'b0}}};
                end
            end
            default: begin
                if (shift_right) begin
                    moved = {{DIST{1'b0}}, data_in[W-1:DIST]};
                end else begin
                    moved = {data_in[W-DIST-1:0], {DIST{1'b0}}};
                end
            end
        endcase
    end

    assign data_out = enable ? moved : data_in;

endmodule

`default_nettype wire

//--- hw/shift_saturate.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module shift_saturate (
    input  wire [`ALU_WIDTH-1:0]        shifted,
    input  wire [`ALU_WIDTH-1:0]        operand,
    input  wire                         shift_right,
    input  wire alu_pkg::shift_kind_e   shift_kind,
    input  wire                         out_of_range,
    output logic [`ALU_WIDTH-1:0]       result
);

    localparam int W = `ALU_WIDTH;

    logic [W-1:0] fill;

    // Value a shift of eight or more places settles to
    always_comb begin
        fill = '0;
        if (shift_kind == alu_pkg::kind_arith) begin
            if (shift_right) begin
                fill = {W{operand[W-1]}};
            end else begin
                fill = {operand[W-1], {(W-1){1'b0}}};
            end
        end
    end

    // Stages only see the low offset bits, so override here
    assign result = out_of_range ? fill : shifted;

endmodule

`default_nettype wire

//--- hw/array_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module array_multiplier (
    input  wire [`ALU_WIDTH-1:0]  multiplicand,
    input  wire [`ALU_WIDTH-1:0]  multiplier,
    output wire [`ALU_WIDTH-1:0]  product
);

    localparam int W = `ALU_WIDTH;

    genvar i;

    // Row i only contributes to product bits i and up, so it is W-i wide.
    // sum holds bits i..W-1 of the running total after row i.
    generate
        for (i = 0; i < W; i++) begin : g_row
            logic [W-1-i:0] row;
            logic [W-1-i:0] sum;

            // Gated partial product
            assign row = multiplicand[W-1-i:0] & {(W-i){multiplier[i]}};

            if (i == 0) begin : g_first
                assign sum = row;
            end else begin : g_acc
                // Drop the settled low bit of the previous row, carry out is discarded
                assign sum = g_row[i-1].sum[W-i:1] + row;
            end

            // Lowest bit of each row is final
            assign product[i] = sum[0];
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          in_valid,
    input  wire alu_pkg::alu_op_e        opcode,
    input  wire [`ALU_WIDTH-1:0]         data1,
    input  wire [`ALU_WIDTH-1:0]         data2,
    output logic                         out_valid,
    output logic [`ALU_WIDTH-1:0]        result,
    output logic                         zero
);

    localparam int W      = `ALU_WIDTH;
    localparam int STAGES = `ALU_SHIFT_STAGES;

    logic [W-1:0]           sum;
    logic [W-1:0]           product;
    logic [W-1:0]           shift_result;
    logic [W-1:0]           next_result;

    logic                   shift_right;
    alu_pkg::shift_kind_e   shift_kind;
    logic [STAGES-1:0]      offset;
    logic                   out_of_range;

    wire  [W-1:0]           stage_data [0:STAGES];

    // Subtraction is an add of the negated operand
    assign sum = data1 + data2;

    shift_control i_shift_control (
        .opcode       (opcode),
        .amount       (data2),
        .shift_right  (shift_right),
        .shift_kind   (shift_kind),
        .offset       (offset),
        .out_of_range (out_of_range)
    );

    // Shared barrel shifter with distances 1, 2, 4
    assign stage_data[0] = data1;

    genvar k;
    generate
        for (k = 0; k < STAGES; k++) begin : g_stage
            shift_stage #(
                .STAGE (k)
            ) i_shift_stage (
                .data_in     (stage_data[k]),
                .enable      (offset[k]),
                .shift_right (shift_right),
                .shift_kind  (shift_kind),
                .data_out    (stage_data[k+1])
            );
        end
    endgenerate

    shift_saturate i_shift_saturate (
        .shifted      (stage_data[STAGES]),
        .operand      (data1),
        .shift_right  (shift_right),
        .shift_kind   (shift_kind),
        .out_of_range (out_of_range),
        .result       (shift_result)
    );

    array_multiplier i_array_multiplier (
        .multiplicand (data1),
        .multiplier   (data2),
        .product      (product)
    );

    always_comb begin
        case (opcode)
            alu_pkg::op_mov: next_result = data2;
            alu_pkg::op_add: next_result = sum;
            alu_pkg::op_and: next_result = data1 & data2;
            alu_pkg::op_or:  next_result = data1 | data2;
            alu_pkg::op_mul: next_result = product;
            // All three shift opcodes share the barrel shifter
            default:         next_result = shift_result;
        endcase
    end

    // One cycle latency; result and zero hold while idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            zero      <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                result <= next_result;
                // Branch-if-equal flag taken from the adder for every opcode
                zero   <= (sum == '0);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/alu_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_assert (
    input wire                   clk,
    input wire                   rst_n,
    input wire                   in_valid,
    input wire                   out_valid,
    input wire [`ALU_WIDTH-1:0]  result
);

    // Reset clears the output valid
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // One cycle latency on the valid bit
    valid_follows_input: assert property (
        @(posedge clk) rst_n |=> (out_valid == $past(in_valid)))
        else $error("out_valid does not follow in_valid of the previous cycle");

    result_known: assert property (@(posedge clk) out_valid |-> !$isunknown(result))
        else $error("result has unknown bits while out_valid is high");

endmodule

bind alu alu_assert i_alu_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

//--- tb/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_tb;

    localparam int CLK_PERIOD  = 4;
    // reset, idle, basic, zero flag, shifts, streaming
    localparam int TEST_CYCLES = 6 + 4 + 121 + 41 + 121 + 129;
    localparam int MARGIN      = 100;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    alu_pkg::alu_op_e        opcode;
    logic [`ALU_WIDTH-1:0]   data1;
    logic [`ALU_WIDTH-1:0]   data2;
    logic                    out_valid;
    logic [`ALU_WIDTH-1:0]   result;
    logic                    zero;

    // Expected DUT state after the most recent rising edge
    logic                    exp_valid;
    logic [`ALU_WIDTH-1:0]   exp_result;
    logic                    exp_zero;
    logic                    zero_known;
    logic [31:0]             lfsr;

    alu i_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .data1     (data1),
        .data2     (data2),
        .out_valid (out_valid),
        .result    (result),
        .zero      (zero)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int count, output logic [7:0] value);
        value = 8'd0;
        for (int b = 0; b < count; b++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // Bit 7 of the amount set means right by the negation
    function automatic logic [7:0] model_shift(input alu_pkg::alu_op_e op,
                                               input logic [7:0] d, input logic [7:0] amt);
        logic               right;
        logic [7:0]         mag;
        logic [15:0]        twice;
        logic signed [7:0]  sd;
        int                 n;
        right = amt[7];
        mag   = right ? (8'd0 - amt) : amt;
        n     = int'(mag);
        twice = {d, d};
        sd    = d;
        if (op == alu_pkg::op_rotate) begin
            // Left rotate by n is a right rotate by 8 - n
            n = right ? (n % 8) : ((8 - (n % 8)) % 8);
            return twice[n +: 8];
        end else if (op == alu_pkg::op_shift_arith) begin
            if (right) begin
                if (n >= 8)
                    return {8{d[7]}};
                return sd >>> n;
            end
            return (n >= 8) ? {d[7], 7'd0} : {d[7], d[6:0] << n};
        end
        if (n >= 8)
            return 8'd0;
        return right ? d >> n : d << n;
    endfunction

    function automatic logic [7:0] model_result(input alu_pkg::alu_op_e op,
                                                input logic [7:0] a, input logic [7:0] b);
        logic [15:0] full;
        full = {8'd0, a} * {8'd0, b};
        case (op)
            alu_pkg::op_mov: return b;
            alu_pkg::op_add: return a + b;
            alu_pkg::op_and: return a & b;
            alu_pkg::op_or:  return a | b;
            alu_pkg::op_mul: return full[7:0];
            default:         return model_shift(op, a, b);
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_outputs();
        assert (out_valid === exp_valid) else begin
            $display("FAILED time=%0t signal=out_valid expected=%b actual=%b",
                     $time, exp_valid, out_valid);
            stop_on_failure();
        end
        assert (result === exp_result) else begin
            $display("FAILED time=%0t signal=result expected=%h actual=%h",
                     $time, exp_result, result);
            stop_on_failure();
        end
        if (zero_known) begin
            assert (zero === exp_zero) else begin
                $display("FAILED time=%0t signal=zero expected=%b actual=%b",
                         $time, exp_zero, zero);
                stop_on_failure();
            end
        end
    endtask

    // Check the previous cycle, then drive the next one
    task automatic drive_cycle(input logic valid, input alu_pkg::alu_op_e op,
                               input logic [7:0] a, input logic [7:0] b);
        logic [7:0] sum;
        @(negedge clk);
        check_outputs();
        in_valid = valid;
        opcode   = op;
        data1    = a;
        data2    = b;
        sum      = a + b;
        if (valid) begin
            exp_result = model_result(op, a, b);
            exp_zero   = (sum == 8'd0);
            zero_known = 1'b1;
        end
        exp_valid = valid;
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        in_valid = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        exp_valid  = 1'b0;
        exp_result = 8'd0;
        zero_known = 1'b0;
    endtask

    task automatic test_reset();
        apply_reset();
        check_outputs();
        // Idle inputs must not disturb the held result
        repeat (4) drive_cycle(1'b0, alu_pkg::op_add, 8'hAA, 8'h55);
    endtask

    task automatic test_basic_ops();
        alu_pkg::alu_op_e ops [0:4] = '{alu_pkg::op_mov, alu_pkg::op_add,
                                        alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_mul};
        logic [7:0]       corners [0:3] = '{8'h00, 8'h01, 8'hFF, 8'h80};
        logic [7:0]       a;
        logic [7:0]       b;
        for (int k = 0; k < 5; k++) begin
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    drive_cycle(1'b1, ops[k], corners[i], corners[j]);
            repeat (8) begin
                rand_bits(8, a);
                rand_bits(8, b);
                drive_cycle(1'b1, ops[k], a, b);
            end
        end
        drive_cycle(1'b0, alu_pkg::op_mov, 8'h00, 8'h00);
    endtask

    task automatic test_zero_flag();
        logic [7:0] lhs [0:4] = '{8'h01, 8'h80, 8'h10, 8'h0F, 8'h01};
        logic [7:0] rhs [0:4] = '{8'hFF, 8'h80, 8'hF0, 8'hF1, 8'h01};
        for (int k = 0; k < 8; k++)
            for (int i = 0; i < 5; i++)
                drive_cycle(1'b1, alu_pkg::alu_op_e'(k), lhs[i], rhs[i]);
        drive_cycle(1'b0, alu_pkg::op_mov, 8'h00, 8'h00);
    endtask

    task automatic test_shifts();
        alu_pkg::alu_op_e ops [0:2] = '{alu_pkg::op_shift_logical, alu_pkg::op_shift_arith,
                                        alu_pkg::op_rotate};
        logic [7:0]       amounts [0:9] = '{8'd0, 8'd1, 8'd3, 8'd7, 8'd8, 8'd9,
                                            8'h7F, 8'hFF, 8'hF9, 8'h80};
        logic [7:0]       values [0:3] = '{8'hB5, 8'h4C, 8'h81, 8'h00};
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 10; i++) begin
                rand_bits(8, values[3]);
                for (int j = 0; j < 4; j++)
                    drive_cycle(1'b1, ops[k], values[j], amounts[i]);
            end
        end
        drive_cycle(1'b0, alu_pkg::op_mov, 8'h00, 8'h00);
    endtask

    task automatic test_streaming();
        logic [7:0] op_bits;
        logic [7:0] valid_bit;
        logic [7:0] a;
        logic [7:0] b;
        for (int pass = 0; pass < 2; pass++) begin
            repeat (64) begin
                rand_bits(3, op_bits);
                rand_bits(8, a);
                rand_bits(8, b);
                // Second run leaves random gaps
                if (pass == 0)
                    valid_bit = 8'd1;
                else
                    rand_bits(1, valid_bit);
                drive_cycle(valid_bit[0], alu_pkg::alu_op_e'(op_bits[2:0]), a, b);
            end
        end
        drive_cycle(1'b0, alu_pkg::op_mov, 8'h00, 8'h00);
    endtask

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("Watchdog expired before the tests finished");
        stop_on_failure();
    end

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        opcode     = alu_pkg::op_mov;
        data1      = 8'd0;
        data2      = 8'd0;
        exp_valid  = 1'b0;
        exp_result = 8'd0;
        exp_zero   = 1'b0;
        zero_known = 1'b0;
        lfsr       = 32'h701;
        test_reset();
        test_basic_ops();
        test_zero_flag();
        test_shifts();
        test_streaming();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hw
hw/alu_pkg.sv
hw/shift_control.sv
hw/shift_stage.sv
hw/shift_saturate.sv
hw/array_multiplier.sv
hw/alu.sv
tb/alu_assert.sv
tb/alu_tb.sv

//--- Makefile
TOP := alu_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
